/* noc_pkg.sv */
/*
 * Mesh router package
 * Widths, flit layout, coordinate types and port naming shared by the
 * single-channel XY router.
 */
package noc_pkg;

  localparam int unsigned NumPorts     = 5;
  localparam int unsigned CoordWidth   = 3;
  localparam int unsigned PayloadWidth = 26;
  localparam int unsigned FlitWidth    = 2 * CoordWidth + PayloadWidth;
  localparam int unsigned FifoDepth    = 2;

  // Input FIFO bookkeeping
  localparam int unsigned FifoPtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned FifoCntWidth = $clog2(FifoDepth + 1);

  // Field positions inside a flit
  localparam int unsigned DstXLsb = PayloadWidth + CoordWidth;
  localparam int unsigned DstYLsb = PayloadWidth;

  typedef logic [CoordWidth-1:0]   coord_t;
  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [FlitWidth-1:0]    flit_t;
  typedef logic [2:0]              port_idx_t;
  typedef logic [NumPorts-1:0]     port_sel_t;

  typedef enum port_idx_t {
    PortNorth = 3'd0,
    PortEast  = 3'd1,
    PortSouth = 3'd2,
    PortWest  = 3'd3,
    PortLocal = 3'd4
  } port_e;

  function automatic coord_t flit_dst_x(input flit_t flit);
    return flit[DstXLsb +: CoordWidth];
  endfunction

  function automatic coord_t flit_dst_y(input flit_t flit);
    return flit[DstYLsb +: CoordWidth];
  endfunction

endpackage

/* noc_input_stage.sv */
/*
 * Router input stage
 * One small circular FIFO per input port, plus dimension-ordered XY
 * route computation on each FIFO head.
 */
module noc_input_stage import noc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  coord_t                    xy_x_i,
  input  coord_t                    xy_y_i,
  input  port_sel_t                 in_valid_i,
  output port_sel_t                 in_ready_o,
  input  flit_t     [NumPorts-1:0]  in_flit_i,
  input  port_sel_t                 pop_i,
  output flit_t     [NumPorts-1:0]  head_flit_o,
  output port_sel_t [NumPorts-1:0]  route_req_o
);

  function automatic logic [FifoPtrWidth-1:0] ptr_next(
    input logic [FifoPtrWidth-1:0] ptr
  );
    if (ptr == FifoPtrWidth'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  for (genvar i = 0; i < NumPorts; i++) begin : gen_fifo
    flit_t                   mem [FifoDepth];
    logic [FifoPtrWidth-1:0] wr_ptr;
    logic [FifoPtrWidth-1:0] rd_ptr;
    logic [FifoCntWidth-1:0] count;
    logic                    push;
    logic                    pop;
    logic                    empty;
    coord_t                  dst_x;
    coord_t                  dst_y;
    port_sel_t               req;

    assign empty         = (count == '0);
    assign in_ready_o[i] = (count != FifoCntWidth'(FifoDepth));
    assign push          = in_valid_i[i] && in_ready_o[i];
    assign pop           = pop_i[i];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= ptr_next(wr_ptr);
        end
        if (pop) begin
          rd_ptr <= ptr_next(rd_ptr);
        end
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    // Flit storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr] <= in_flit_i[i];
      end
    end

    assign head_flit_o[i] = mem[rd_ptr];
    assign dst_x          = flit_dst_x(head_flit_o[i]);
    assign dst_y          = flit_dst_y(head_flit_o[i]);

    // Resolve x first, then y, else deliver locally
    always_comb begin
      req = '0;
      if (!empty) begin
        if (dst_x > xy_x_i) begin
          req[PortEast] = 1'b1;
        end else if (dst_x < xy_x_i) begin
          req[PortWest] = 1'b1;
        end else if (dst_y > xy_y_i) begin
          req[PortNorth] = 1'b1;
        end else if (dst_y < xy_y_i) begin
          req[PortSouth] = 1'b1;
        end else begin
          req[PortLocal] = 1'b1;
        end
      end
    end

    assign route_req_o[i] = req;

    // Arbiters only grant a requesting head, so an empty FIFO is never popped
    assert property (@(posedge clk_i) disable iff (reset_i)
      pop_i[i] |-> !empty)
      else $error("pop on empty input FIFO %0d", i);
  end

endmodule

/* noc_output_arbiter.sv */
/*
 * Output port arbiter
 * Round-robin choice of one requesting input, granted only while the
 * output slot can take a flit.
 */
module noc_output_arbiter import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  port_sel_t req_i,
  input  logic      slot_free_i,
  output port_sel_t gnt_o
);

  port_idx_t rr_ptr;
  port_idx_t win_idx;
  logic      win_found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    gnt_o     = '0;
    win_idx   = rr_ptr;
    win_found = 1'b0;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      idx = rr_ptr + k;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!win_found && req_i[idx]) begin
        win_found = 1'b1;
        win_idx   = port_idx_t'(idx);
      end
    end
    if (slot_free_i && win_found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // Winner moves to lowest priority for the next round
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
    end else if (|gnt_o) begin
      if (win_idx == port_idx_t'(NumPorts - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= win_idx + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("arbiter grant not one-hot or not requested: %b", gnt_o);

endmodule

/* noc_output_stage.sv */
/*
 * Router output stage
 * One registered slot per output port, loaded from the granted input
 * head and released on the output valid/ready handshake.
 */
module noc_output_stage import noc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  port_sel_t [NumPorts-1:0]  gnt_i,
  input  flit_t     [NumPorts-1:0]  head_flit_i,
  output port_sel_t                 slot_free_o,
  output port_sel_t                 out_valid_o,
  input  port_sel_t                 out_ready_i,
  output flit_t     [NumPorts-1:0]  out_flit_o
);

  for (genvar k = 0; k < NumPorts; k++) begin : gen_slot
    logic  load;
    logic  slot_valid;
    flit_t slot_flit;
    flit_t sel_flit;

    assign load = |gnt_i[k];

    // AND-OR mux, the grant is one-hot
    always_comb begin
      sel_flit = '0;
      for (int j = 0; j < NumPorts; j++) begin
        sel_flit = sel_flit | (head_flit_i[j] & {FlitWidth{gnt_i[k][j]}});
      end
    end

    // Free if empty or emptied by this cycle's handshake
    assign slot_free_o[k] = !slot_valid || out_ready_i[k];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        slot_valid <= 1'b0;
      end else if (load) begin
        slot_valid <= 1'b1;
      end else if (out_ready_i[k]) begin
        slot_valid <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        slot_flit <= sel_flit;
      end
    end

    assign out_valid_o[k] = slot_valid;
    assign out_flit_o[k]  = slot_flit;

    // Stalled output must hold, which relies on the arbiter seeing slot_free low
    assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_o[k] && !out_ready_i[k] |=> out_valid_o[k] && $stable(out_flit_o[k]))
      else $error("output %0d dropped or changed a stalled flit", k);
  end

endmodule

/* noc_router.sv */
/*
 * Five-port XY mesh router
 * Input FIFOs with route computation, one round-robin arbiter per
 * output and a registered output slice on every port.
 */
module noc_router import noc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  coord_t                   xy_x_i,
  input  coord_t                   xy_y_i,
  input  port_sel_t                in_valid_i,
  output port_sel_t                in_ready_o,
  input  flit_t     [NumPorts-1:0] in_flit_i,
  output port_sel_t                out_valid_o,
  input  port_sel_t                out_ready_i,
  output flit_t     [NumPorts-1:0] out_flit_o
);

  flit_t     [NumPorts-1:0] head_flit;
  port_sel_t [NumPorts-1:0] route_req;
  port_sel_t [NumPorts-1:0] arb_req;
  port_sel_t [NumPorts-1:0] gnt;
  port_sel_t                pop;
  port_sel_t                slot_free;

  noc_input_stage noc_input_stage_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .xy_x_i      ( xy_x_i      ),
    .xy_y_i      ( xy_y_i      ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_flit_i   ( in_flit_i   ),
    .pop_i       ( pop         ),
    .head_flit_o ( head_flit   ),
    .route_req_o ( route_req   )
  );

  // Requests are per input, arbiters want them per output
  always_comb begin
    pop = '0;
    for (int k = 0; k < NumPorts; k++) begin
      for (int j = 0; j < NumPorts; j++) begin
        arb_req[k][j] = route_req[j][k];
        pop[j]        = pop[j] | gnt[k][j];
      end
    end
  end

  for (genvar k = 0; k < NumPorts; k++) begin : gen_out_arb
    noc_output_arbiter noc_output_arbiter_inst (
      .clk_i       ( clk_i        ),
      .reset_i     ( reset_i      ),
      .req_i       ( arb_req[k]   ),
      .slot_free_i ( slot_free[k] ),
      .gnt_o       ( gnt[k]       )
    );
  end

  noc_output_stage noc_output_stage_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .gnt_i       ( gnt         ),
    .head_flit_i ( head_flit   ),
    .slot_free_o ( slot_free   ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_flit_o  ( out_flit_o  )
  );

endmodule

/* noc_router_tb.sv */
/*
 * Testbench for the five-port XY mesh router
 * Drives the flits listed in router_cases.txt, applies random and stalled
 * output back-pressure and scores every output handshake.
 */
module noc_router_tb import noc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxCases = 64;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  coord_t                   xy_x_i;
  coord_t                   xy_y_i;
  port_sel_t                in_valid_i;
  port_sel_t                in_ready_o;
  flit_t     [NumPorts-1:0] in_flit_i;
  port_sel_t                out_valid_o;
  port_sel_t                out_ready_i;
  flit_t     [NumPorts-1:0] out_flit_o;

  // Case table and expected flits per (input, output) pair
  int       case_in [MaxCases];
  coord_t   case_x  [MaxCases];
  coord_t   case_y  [MaxCases];
  payload_t case_pl [MaxCases];
  flit_t    exp_q   [NumPorts*NumPorts][$];
  int       num_cases;
  int       recv_count;
  int       cycle_cnt;
  int       cycle_limit;
  int       phase;
  int       seed = 84818;
  logic     running;
  logic     drv_valid [NumPorts];
  flit_t    drv_flit  [NumPorts];
  logic     drv_done  [NumPorts];

  noc_router noc_router_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .xy_x_i      ( xy_x_i      ),
    .xy_y_i      ( xy_y_i      ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_flit_i   ( in_flit_i   ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_flit_o  ( out_flit_o  )
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  function automatic logic all_sent();
    for (int i = 0; i < NumPorts; i++) begin
      if (!drv_done[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic queues_empty();
    for (int q = 0; q < NumPorts * NumPorts; q++) begin
      if (exp_q[q].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // One driver per input, each flit held until the FIFO takes it
  for (genvar i = 0; i < NumPorts; i++) begin : gen_drv
    assign in_valid_i[i] = drv_valid[i];
    assign in_flit_i[i]  = drv_flit[i];

    initial begin
      drv_valid[i] = 1'b0;
      drv_flit[i]  = '0;
      drv_done[i]  = 1'b0;
      wait (running);
      @(posedge clk_i);
      for (int c = 0; c < num_cases; c++) begin
        if (case_in[c] == i) begin
          drv_valid[i] <= 1'b1;
          drv_flit[i]  <= {case_x[c], case_y[c], case_pl[c]};
          @(posedge clk_i);
          while (!in_ready_o[i]) begin
            @(posedge clk_i);
          end
        end
      end
      drv_valid[i] <= 1'b0;
      drv_done[i]  = 1'b1;
    end
  end

  // Scoreboard per output, the payload tag names the source input
  for (genvar k = 0; k < NumPorts; k++) begin : gen_mon
    logic  held = 1'b0;
    flit_t held_flit;

    always @(posedge clk_i) begin
      int    src;
      flit_t expected;
      if (running) begin
        if (held) begin
          check_value($sformatf("out_valid_o[%0d]", k), out_valid_o[k], 1);
          check_value($sformatf("out_flit_o[%0d]", k), out_flit_o[k], held_flit);
        end
        held      = out_valid_o[k] && !out_ready_i[k];
        held_flit = out_flit_o[k];
        if (out_valid_o[k] && out_ready_i[k]) begin
          src = int'(out_flit_o[k][PayloadWidth-1 -: 3]);
          if (src >= NumPorts || exp_q[src*NumPorts+k].size() == 0) begin
            stop_run($sformatf("output %0d delivered flit 0x%08h that no case expects",
                               k, out_flit_o[k]));
          end
          expected = exp_q[src*NumPorts+k].pop_front();
          check_value($sformatf("out_flit_o[%0d]", k), out_flit_o[k], expected);
          recv_count++;
        end
      end
    end
  end

  // Random ready with a full stall for the second half of every 48 cycles
  always @(posedge clk_i) begin
    int rnd;
    if (running) begin
      phase++;
      if (phase % 48 >= 24) begin
        out_ready_i <= '0;
      end else begin
        rnd = $random(seed);
        out_ready_i <= port_sel_t'(rnd);
      end
      // After a long stall every input still offering a flit must be full
      if (phase % 48 == 47) begin
        for (int i = 0; i < NumPorts; i++) begin
          if (drv_valid[i]) begin
            check_value($sformatf("in_ready_o[%0d]", i), in_ready_o[i], 0);
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (running) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        stop_run($sformatf("timeout after %0d cycles, only %0d of %0d flits delivered",
                           cycle_cnt, recv_count, num_cases));
      end
    end
  end

  initial begin
    int          fd;
    int          rc;
    int          n;
    int          pin;
    int          px;
    int          py;
    int          pout;
    logic [31:0] ppl;
    string       line;
    reset_i     = 1'b1;
    xy_x_i      = 3'd3;
    xy_y_i      = 3'd3;
    out_ready_i = '0;
    running     = 1'b0;
    num_cases   = 0;
    recv_count  = 0;
    cycle_cnt   = 0;
    phase       = 0;
    fd = $fopen("router_cases.txt", "r");
    if (fd == 0) begin
      stop_run("could not open router_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %d %d %h %d", pin, px, py, ppl, pout);
        if (n != 5 || pin >= NumPorts || pout >= NumPorts || num_cases >= MaxCases) begin
          stop_run($sformatf("bad line in router_cases.txt after case %0d", num_cases));
        end
        if (ppl[PayloadWidth-1 -: 3] != pin[2:0]) begin
          stop_run($sformatf("case %0d payload tag does not match its input port", num_cases));
        end
        case_in[num_cases] = pin;
        case_x[num_cases]  = coord_t'(px);
        case_y[num_cases]  = coord_t'(py);
        case_pl[num_cases] = payload_t'(ppl);
        exp_q[pin*NumPorts+pout].push_back({coord_t'(px), coord_t'(py), payload_t'(ppl)});
        num_cases++;
      end
    end
    $fclose(fd);
    cycle_limit = 40 * num_cases + 200;

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("out_valid_o", out_valid_o, 0);
    check_value("in_ready_o", in_ready_o, {NumPorts{1'b1}});
    running <= 1'b1;

    while (!(all_sent() && queues_empty())) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    if (recv_count != num_cases || out_valid_o != '0) begin
      stop_run($sformatf("%0d flits delivered for %0d cases, or an extra flit is pending",
                         recv_count, num_cases));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* router_cases.txt */
# in_port dst_x dst_y payload_hex out_port  (router sits at x 3, y 3)
# ports: 0 North, 1 East, 2 South, 3 West, 4 Local; payload bits 25:23 = in_port
0 5 1 0000001 1
0 3 6 0000002 0
0 3 3 0000003 4
0 1 7 0000004 3
0 3 0 0000005 2
0 4 4 0000006 1
0 3 3 0000007 4
0 7 0 0000008 1
1 3 3 0800001 4
1 3 3 0800002 4
1 3 3 0800003 4
1 0 3 0800004 3
1 3 5 0800005 0
1 2 2 0800006 3
1 3 1 0800007 2
1 3 3 0800008 4
2 3 3 1000001 4
2 3 3 1000002 4
2 6 3 1000003 1
2 3 7 1000004 0
2 3 2 1000005 2
2 0 0 1000006 3
2 3 3 1000007 4
2 5 5 1000008 1
3 3 3 1800001 4
3 7 7 1800002 1
3 3 4 1800003 0
3 3 3 1800004 4
3 1 1 1800005 3
3 3 0 1800006 2
3 4 2 1800007 1
3 3 3 1800008 4
4 3 3 2000001 4
4 4 3 2000002 1
4 2 3 2000003 3
4 3 4 2000004 0
4 3 2 2000005 2
4 3 3 2000006 4
4 6 1 2000007 1
4 0 6 2000008 3

/* flist.f */
noc_pkg.sv
noc_input_stage.sv
noc_output_arbiter.sv
noc_output_stage.sv
noc_router.sv
noc_router_tb.sv

/* Bender.yml */
package:
  name: noc_router

dependencies: {}

sources:
  # RTL in compile order
  - noc_pkg.sv
  - noc_input_stage.sv
  - noc_output_arbiter.sv
  - noc_output_stage.sv
  - noc_router.sv
  # Testbench
  - target: simulation
    files:
      - noc_router_tb.sv
